//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := tb_load_queue
FLIST     := sim.f
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- load_queue_top.sv
module load_queue_top (
    input  logic                         clk,
    input  logic                         i_rst_n,
    input  logic                         i_flush,
    input  logic [lsq_pkg::LDU_NUM-1:0]  i_ld_vld,
    input  lsq_pkg::lq_idx_t             i_ld_lq_idx  [lsq_pkg::LDU_NUM],
    input  lsq_pkg::sq_idx_t             i_ld_sq_idx  [lsq_pkg::LDU_NUM],
    input  lsq_pkg::paddr_t              i_ld_paddr   [lsq_pkg::LDU_NUM],
    input  lsq_pkg::byte_mask_t          i_ld_mask    [lsq_pkg::LDU_NUM],
    input  lsq_pkg::rob_idx_t            i_ld_rob_idx [lsq_pkg::LDU_NUM],
    input  lsq_pkg::pc_t                 i_ld_pc      [lsq_pkg::LDU_NUM],
    input  lsq_pkg::commit_cnt_t         i_commit_cnt,
    input  logic [lsq_pkg::STU_NUM-1:0]  i_st_vld,
    input  lsq_pkg::sq_idx_t             i_st_sq_idx [lsq_pkg::STU_NUM],
    input  lsq_pkg::paddr_t              i_st_paddr  [lsq_pkg::STU_NUM],
    input  lsq_pkg::byte_mask_t          i_st_mask   [lsq_pkg::STU_NUM],
    output logic [lsq_pkg::STU_NUM-1:0]  o_vio,
    output lsq_pkg::rob_idx_t            o_vio_rob_idx [lsq_pkg::STU_NUM],
    output lsq_pkg::pc_t                 o_vio_pc      [lsq_pkg::STU_NUM]
);

    logic [lsq_pkg::LQ_DEPTH-1:0] nxt_vld;
    lsq_pkg::sq_idx_t             nxt_sq_idx  [lsq_pkg::LQ_DEPTH];
    lsq_pkg::paddr_t              nxt_paddr   [lsq_pkg::LQ_DEPTH];
    lsq_pkg::byte_mask_t          nxt_mask    [lsq_pkg::LQ_DEPTH];
    lsq_pkg::rob_idx_t            nxt_rob_idx [lsq_pkg::LQ_DEPTH];
    lsq_pkg::pc_t                 nxt_pc      [lsq_pkg::LQ_DEPTH];
    logic [lsq_pkg::LQ_DEPTH-1:0] match [lsq_pkg::STU_NUM];

    lq_entry_store u_entry_store (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_flush       (i_flush),
        .i_ld_vld      (i_ld_vld),
        .i_ld_lq_idx   (i_ld_lq_idx),
        .i_ld_sq_idx   (i_ld_sq_idx),
        .i_ld_paddr    (i_ld_paddr),
        .i_ld_mask     (i_ld_mask),
        .i_ld_rob_idx  (i_ld_rob_idx),
        .i_ld_pc       (i_ld_pc),
        .i_commit_cnt  (i_commit_cnt),
        .o_nxt_vld     (nxt_vld),
        .o_nxt_sq_idx  (nxt_sq_idx),
        .o_nxt_paddr   (nxt_paddr),
        .o_nxt_mask    (nxt_mask),
        .o_nxt_rob_idx (nxt_rob_idx),
        .o_nxt_pc      (nxt_pc)
    );

    // checked against the next-state view so same-cycle writes are seen
    lq_violation_check u_violation_check (
        .i_vld       (nxt_vld),
        .i_sq_idx    (nxt_sq_idx),
        .i_paddr     (nxt_paddr),
        .i_mask      (nxt_mask),
        .i_st_vld    (i_st_vld),
        .i_st_sq_idx (i_st_sq_idx),
        .i_st_paddr  (i_st_paddr),
        .i_st_mask   (i_st_mask),
        .o_match     (match)
    );

    lq_vio_report u_vio_report (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_flush       (i_flush),
        .i_match       (match),
        .i_rob_idx     (nxt_rob_idx),
        .i_pc          (nxt_pc),
        .o_vio         (o_vio),
        .o_vio_rob_idx (o_vio_rob_idx),
        .o_vio_pc      (o_vio_pc)
    );

endmodule

//--- lq_entry_store.sv
module lq_entry_store (
    input  logic                                 clk,
    input  logic                                 i_rst_n,
    input  logic                                 i_flush,
    input  logic [lsq_pkg::LDU_NUM-1:0]          i_ld_vld,
    input  lsq_pkg::lq_idx_t                     i_ld_lq_idx  [lsq_pkg::LDU_NUM],
    input  lsq_pkg::sq_idx_t                     i_ld_sq_idx  [lsq_pkg::LDU_NUM],
    input  lsq_pkg::paddr_t                      i_ld_paddr   [lsq_pkg::LDU_NUM],
    input  lsq_pkg::byte_mask_t                  i_ld_mask    [lsq_pkg::LDU_NUM],
    input  lsq_pkg::rob_idx_t                    i_ld_rob_idx [lsq_pkg::LDU_NUM],
    input  lsq_pkg::pc_t                         i_ld_pc      [lsq_pkg::LDU_NUM],
    input  lsq_pkg::commit_cnt_t                 i_commit_cnt,
    output logic [lsq_pkg::LQ_DEPTH-1:0]         o_nxt_vld,
    output lsq_pkg::sq_idx_t                     o_nxt_sq_idx  [lsq_pkg::LQ_DEPTH],
    output lsq_pkg::paddr_t                      o_nxt_paddr   [lsq_pkg::LQ_DEPTH],
    output lsq_pkg::byte_mask_t                  o_nxt_mask    [lsq_pkg::LQ_DEPTH],
    output lsq_pkg::rob_idx_t                    o_nxt_rob_idx [lsq_pkg::LQ_DEPTH],
    output lsq_pkg::pc_t                         o_nxt_pc      [lsq_pkg::LQ_DEPTH]
);

    logic [lsq_pkg::LQ_DEPTH-1:0] ent_vld;
    lsq_pkg::sq_idx_t             ent_sq_idx  [lsq_pkg::LQ_DEPTH];
    lsq_pkg::paddr_t              ent_paddr   [lsq_pkg::LQ_DEPTH];
    lsq_pkg::byte_mask_t          ent_mask    [lsq_pkg::LQ_DEPTH];
    lsq_pkg::rob_idx_t            ent_rob_idx [lsq_pkg::LQ_DEPTH];
    lsq_pkg::pc_t                 ent_pc      [lsq_pkg::LQ_DEPTH];

    lsq_pkg::lq_idx_t             head;
    logic [lsq_pkg::LQ_DEPTH-1:0] commit_clr;

    // current contents plus this cycle's writes with port 1 applied last
    always_comb begin
        o_nxt_vld = ent_vld;
        for (int j = 0; j < lsq_pkg::LQ_DEPTH; j++) begin
            o_nxt_sq_idx[j]  = ent_sq_idx[j];
            o_nxt_paddr[j]   = ent_paddr[j];
            o_nxt_mask[j]    = ent_mask[j];
            o_nxt_rob_idx[j] = ent_rob_idx[j];
            o_nxt_pc[j]      = ent_pc[j];
        end
        for (int p = 0; p < lsq_pkg::LDU_NUM; p++) begin
            if (i_ld_vld[p]) begin
                o_nxt_vld[i_ld_lq_idx[p]]     = 1'b1;
                o_nxt_sq_idx[i_ld_lq_idx[p]]  = i_ld_sq_idx[p];
                o_nxt_paddr[i_ld_lq_idx[p]]   = i_ld_paddr[p];
                o_nxt_mask[i_ld_lq_idx[p]]    = i_ld_mask[p];
                o_nxt_rob_idx[i_ld_lq_idx[p]] = i_ld_rob_idx[p];
                o_nxt_pc[i_ld_lq_idx[p]]      = i_ld_pc[p];
            end
        end
    end

    // slots freed by commit walk up from head and wrap
    always_comb begin
        lsq_pkg::lq_idx_t slot;
        commit_clr = '0;
        slot = head;
        for (int k = 0; k < lsq_pkg::COMMIT_WIDTH; k++) begin
            if (k < int'(i_commit_cnt)) begin
                commit_clr[slot] = 1'b1;
            end
            slot = slot + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n || i_flush) begin
            ent_vld <= '0;
            head    <= '0;
        end else begin
            ent_vld <= o_nxt_vld & ~commit_clr;
            head    <= head + {1'b0, i_commit_cnt};
        end
    end

    always_ff @(posedge clk) begin
        for (int j = 0; j < lsq_pkg::LQ_DEPTH; j++) begin
            ent_sq_idx[j]  <= o_nxt_sq_idx[j];
            ent_paddr[j]   <= o_nxt_paddr[j];
            ent_mask[j]    <= o_nxt_mask[j];
            ent_rob_idx[j] <= o_nxt_rob_idx[j];
            ent_pc[j]      <= o_nxt_pc[j];
        end
    end

endmodule

//--- lq_oldest_select.sv
module lq_oldest_select (
    input  logic [lsq_pkg::LQ_DEPTH-1:0] i_match,
    input  lsq_pkg::rob_idx_t            i_rob_idx [lsq_pkg::LQ_DEPTH],
    output logic                         o_any,
    output lsq_pkg::lq_idx_t             o_sel_idx
);

    // heap layout with the root at 1 and leaf n at LQ_DEPTH+n
    logic              node_vld [1:2*lsq_pkg::LQ_DEPTH-1];
    lsq_pkg::rob_idx_t node_rob [1:2*lsq_pkg::LQ_DEPTH-1];
    lsq_pkg::lq_idx_t  node_idx [1:2*lsq_pkg::LQ_DEPTH-1];

    genvar n, k;

    generate
        for (n = 0; n < lsq_pkg::LQ_DEPTH; n++) begin : g_leaf
            assign node_vld[lsq_pkg::LQ_DEPTH+n] = i_match[n];
            assign node_rob[lsq_pkg::LQ_DEPTH+n] = i_rob_idx[n];
            assign node_idx[lsq_pkg::LQ_DEPTH+n] = lsq_pkg::lq_idx_t'(n);
        end

        for (k = 1; k < lsq_pkg::LQ_DEPTH; k++) begin : g_node
            logic take_r;

            // left child holds the lower indices, so it keeps ties
            assign take_r = node_vld[2*k+1] &&
                            (!node_vld[2*k] ||
                             lsq_pkg::rob_older(node_rob[2*k+1], node_rob[2*k]));

            assign node_vld[k] = node_vld[2*k] || node_vld[2*k+1];
            assign node_rob[k] = take_r ? node_rob[2*k+1] : node_rob[2*k];
            assign node_idx[k] = take_r ? node_idx[2*k+1] : node_idx[2*k];
        end
    endgenerate

    assign o_any     = node_vld[1];
    assign o_sel_idx = node_idx[1];

endmodule

//--- lq_vectors.txt
# columns (hex): op grp port idx sq paddr mask rob pc vio, grp 1 joins the next line's cycle
# op 1 write at slot idx, 2 commit idx loads, 3 flush, 4 store with expected rob pc vio, 5 store strobe low
1 0 0 0 05 00001000 0f 02 80000000 0
4 0 0 0 03 00001002 0c 02 80000000 1
4 0 1 0 06 00001000 0f 00 00000000 0
4 0 1 0 03 00001008 0f 00 00000000 0
4 0 0 0 03 00001000 f0 00 00000000 0
5 0 1 0 03 00001000 0f 00 00000000 0
1 1 0 1 08 00002000 ff 3d 80000100 0
1 0 1 2 09 00002000 ff 3f 80000104 0
1 0 0 3 0a 00002000 ff 01 80000108 0
4 1 0 0 07 00002000 ff 3d 80000100 1
4 0 1 0 03 00001000 01 02 80000000 1
1 1 1 4 0c 00003000 30 05 80000200 0
4 0 0 0 0b 00003000 10 05 80000200 1
2 0 0 2 00 00000000 00 00 00000000 0
4 1 0 0 07 00002000 ff 3f 80000104 1
4 0 1 0 03 00001000 01 00 00000000 0
2 0 0 2 00 00000000 00 00 00000000 0
2 0 0 4 00 00000000 00 00 00000000 0
2 0 0 4 00 00000000 00 00 00000000 0
2 0 0 3 00 00000000 00 00 00000000 0
1 1 0 f 12 00004000 01 10 80000300 0
1 0 1 0 13 00004000 01 11 80000304 0
4 0 0 0 0f 00004000 01 10 80000300 1
2 0 0 1 00 00000000 00 00 00000000 0
4 0 1 0 0f 00004000 01 11 80000304 1
4 0 0 0 0b 00003000 10 00 00000000 0
3 0 0 0 00 00000000 00 00 00000000 0
4 1 0 0 0f 00004000 01 00 00000000 0
4 0 1 0 03 00001000 01 00 00000000 0

//--- lq_vio_report.sv
module lq_vio_report (
    input  logic                         clk,
    input  logic                         i_rst_n,
    input  logic                         i_flush,
    input  logic [lsq_pkg::LQ_DEPTH-1:0] i_match [lsq_pkg::STU_NUM],
    input  lsq_pkg::rob_idx_t            i_rob_idx [lsq_pkg::LQ_DEPTH],
    input  lsq_pkg::pc_t                 i_pc      [lsq_pkg::LQ_DEPTH],
    output logic [lsq_pkg::STU_NUM-1:0]  o_vio,
    output lsq_pkg::rob_idx_t            o_vio_rob_idx [lsq_pkg::STU_NUM],
    output lsq_pkg::pc_t                 o_vio_pc      [lsq_pkg::STU_NUM]
);

    genvar s;

    generate
        for (s = 0; s < lsq_pkg::STU_NUM; s++) begin : g_port
            logic             any;
            lsq_pkg::lq_idx_t sel_idx;

            lq_oldest_select u_oldest_select (
                .i_match   (i_match[s]),
                .i_rob_idx (i_rob_idx),
                .o_any     (any),
                .o_sel_idx (sel_idx)
            );

            always_ff @(posedge clk) begin
                if (!i_rst_n || i_flush) begin
                    o_vio[s] <= 1'b0;
                end else begin
                    o_vio[s] <= any;
                end
            end

            // rob index and pc of the oldest match
            always_ff @(posedge clk) begin
                o_vio_rob_idx[s] <= i_rob_idx[sel_idx];
                o_vio_pc[s]      <= i_pc[sel_idx];
            end
        end
    endgenerate

endmodule

//--- lq_violation_check.sv
module lq_violation_check (
    input  logic [lsq_pkg::LQ_DEPTH-1:0] i_vld,
    input  lsq_pkg::sq_idx_t             i_sq_idx [lsq_pkg::LQ_DEPTH],
    input  lsq_pkg::paddr_t              i_paddr  [lsq_pkg::LQ_DEPTH],
    input  lsq_pkg::byte_mask_t          i_mask   [lsq_pkg::LQ_DEPTH],
    input  logic [lsq_pkg::STU_NUM-1:0]  i_st_vld,
    input  lsq_pkg::sq_idx_t             i_st_sq_idx [lsq_pkg::STU_NUM],
    input  lsq_pkg::paddr_t              i_st_paddr  [lsq_pkg::STU_NUM],
    input  lsq_pkg::byte_mask_t          i_st_mask   [lsq_pkg::STU_NUM],
    output logic [lsq_pkg::LQ_DEPTH-1:0] o_match [lsq_pkg::STU_NUM]
);

    genvar s, j;

    generate
        for (s = 0; s < lsq_pkg::STU_NUM; s++) begin : g_st
            for (j = 0; j < lsq_pkg::LQ_DEPTH; j++) begin : g_ent
                logic younger;
                logic same_word;
                logic overlap;

                assign younger   = lsq_pkg::sq_after(i_sq_idx[j], i_st_sq_idx[s]);
                // compare at 8-byte granularity
                assign same_word = i_paddr[j][lsq_pkg::PALEN-1:3] ==
                                   i_st_paddr[s][lsq_pkg::PALEN-1:3];
                assign overlap   = |(i_mask[j] & i_st_mask[s]);

                assign o_match[s][j] = i_st_vld[s] && i_vld[j] && younger &&
                                       same_word && overlap;
            end
        end
    endgenerate

endmodule

//--- lsq_pkg.sv
package lsq_pkg;

    localparam int LQ_DEPTH     = 16;
    localparam int LQ_IDX_W     = $clog2(LQ_DEPTH);
    localparam int LDU_NUM      = 2;
    localparam int STU_NUM      = 2;
    localparam int COMMIT_WIDTH = 4;
    localparam int PALEN        = 32;

    typedef logic [LQ_IDX_W-1:0] lq_idx_t;
    typedef logic [2:0]          commit_cnt_t;
    // wrap flag in the top bit
    typedef logic [4:0]          sq_idx_t;
    typedef logic [5:0]          rob_idx_t;
    typedef logic [PALEN-1:0]    paddr_t;
    typedef logic [7:0]          byte_mask_t;
    typedef logic [31:0]         pc_t;

    // load sits later in store order than the store
    function automatic logic sq_after(sq_idx_t ld_pos, sq_idx_t st_pos);
        if (ld_pos[4] == st_pos[4]) begin
            return ld_pos[3:0] > st_pos[3:0];
        end
        return ld_pos[3:0] < st_pos[3:0];
    endfunction

    // a was dispatched before b
    function automatic logic rob_older(rob_idx_t a, rob_idx_t b);
        if (a[5] == b[5]) begin
            return a[4:0] < b[4:0];
        end
        return a[4:0] > b[4:0];
    endfunction

endpackage

//--- sim.f
lsq_pkg.sv
lq_entry_store.sv
lq_violation_check.sv
lq_oldest_select.sv
lq_vio_report.sv
load_queue_top.sv
tb_load_queue.sv

//--- tb_load_queue.sv
module tb_load_queue;

    localparam int MAX_LINES = 64;
    localparam int NCOL      = 10;

    logic                        clk;
    logic                        rst_n;
    logic                        flush;
    logic [lsq_pkg::LDU_NUM-1:0] ld_vld;
    lsq_pkg::lq_idx_t            ld_lq_idx  [lsq_pkg::LDU_NUM];
    lsq_pkg::sq_idx_t            ld_sq_idx  [lsq_pkg::LDU_NUM];
    lsq_pkg::paddr_t             ld_paddr   [lsq_pkg::LDU_NUM];
    lsq_pkg::byte_mask_t         ld_mask    [lsq_pkg::LDU_NUM];
    lsq_pkg::rob_idx_t           ld_rob_idx [lsq_pkg::LDU_NUM];
    lsq_pkg::pc_t                ld_pc      [lsq_pkg::LDU_NUM];
    lsq_pkg::commit_cnt_t        commit_cnt;
    logic [lsq_pkg::STU_NUM-1:0] st_vld;
    lsq_pkg::sq_idx_t            st_sq_idx [lsq_pkg::STU_NUM];
    lsq_pkg::paddr_t             st_paddr  [lsq_pkg::STU_NUM];
    lsq_pkg::byte_mask_t         st_mask   [lsq_pkg::STU_NUM];
    logic [lsq_pkg::STU_NUM-1:0] vio;
    lsq_pkg::rob_idx_t           vio_rob_idx [lsq_pkg::STU_NUM];
    lsq_pkg::pc_t                vio_pc      [lsq_pkg::STU_NUM];

    // one row per operation with op grp port idx sq paddr mask rob pc vio
    logic [31:0]                 vec [MAX_LINES][NCOL];
    int                          n_lines;
    int                          cycles;
    int                          limit;
    logic [lsq_pkg::STU_NUM-1:0] chk_pend;
    logic [lsq_pkg::STU_NUM-1:0] exp_vio;
    lsq_pkg::rob_idx_t           exp_rob [lsq_pkg::STU_NUM];
    lsq_pkg::pc_t                exp_pc  [lsq_pkg::STU_NUM];

    load_queue_top i_dut (
        .clk           (clk),
        .i_rst_n       (rst_n),
        .i_flush       (flush),
        .i_ld_vld      (ld_vld),
        .i_ld_lq_idx   (ld_lq_idx),
        .i_ld_sq_idx   (ld_sq_idx),
        .i_ld_paddr    (ld_paddr),
        .i_ld_mask     (ld_mask),
        .i_ld_rob_idx  (ld_rob_idx),
        .i_ld_pc       (ld_pc),
        .i_commit_cnt  (commit_cnt),
        .i_st_vld      (st_vld),
        .i_st_sq_idx   (st_sq_idx),
        .i_st_paddr    (st_paddr),
        .i_st_mask     (st_mask),
        .o_vio         (vio),
        .o_vio_rob_idx (vio_rob_idx),
        .o_vio_pc      (vio_pc)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: no end of run after %0d cycles", limit);
            $display("TEST FAILED");
            $fatal(1, "run stopped by cycle limit");
        end
    end

    task automatic stop_run(string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic report_mismatch(int port, string what, logic [31:0] got, logic [31:0] exp);
        $display("[ERROR] t=%0t port %0d %s: got %h, expected %h", $time, port, what, got, exp);
        $display("TEST FAILED");
        $fatal(1, "mismatch on store port %0d", port);
    endtask

    task automatic load_vectors();
        int          fd;
        int          cnt;
        string       line;
        logic [31:0] f [NCOL];
        fd = $fopen("lq_vectors.txt", "r");
        if (fd == 0) begin
            stop_run("could not open the vector file lq_vectors.txt");
        end
        n_lines = 0;
        while (!$feof(fd) && n_lines < MAX_LINES) begin
            line = "";
            void'($fgets(line, fd));
            cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                          f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
            // comment and blank lines do not scan as numbers
            if (cnt == NCOL) begin
                for (int c = 0; c < NCOL; c++) begin
                    vec[n_lines][c] = f[c];
                end
                n_lines++;
            end
        end
        $fclose(fd);
        if (n_lines == 0) begin
            stop_run("the vector file holds no operations");
        end
    endtask

    task automatic clear_inputs();
        flush      = 1'b0;
        ld_vld     = '0;
        st_vld     = '0;
        commit_cnt = '0;
        for (int p = 0; p < lsq_pkg::LDU_NUM; p++) begin
            ld_lq_idx[p]  = '0;
            ld_sq_idx[p]  = '0;
            ld_paddr[p]   = '0;
            ld_mask[p]    = '0;
            ld_rob_idx[p] = '0;
            ld_pc[p]      = '0;
        end
        for (int s = 0; s < lsq_pkg::STU_NUM; s++) begin
            st_sq_idx[s] = '0;
            st_paddr[s]  = '0;
            st_mask[s]   = '0;
        end
    endtask

    task automatic apply_line(int n);
        int p;
        p = int'(vec[n][2]);
        case (vec[n][0])
            32'd1: begin
                ld_vld[p]     = 1'b1;
                ld_lq_idx[p]  = lsq_pkg::lq_idx_t'(vec[n][3]);
                ld_sq_idx[p]  = lsq_pkg::sq_idx_t'(vec[n][4]);
                ld_paddr[p]   = vec[n][5];
                ld_mask[p]    = lsq_pkg::byte_mask_t'(vec[n][6]);
                ld_rob_idx[p] = lsq_pkg::rob_idx_t'(vec[n][7]);
                ld_pc[p]      = vec[n][8];
            end
            32'd2: commit_cnt = lsq_pkg::commit_cnt_t'(vec[n][3]);
            32'd3: flush = 1'b1;
            // op 5 presents the store with its strobe low
            32'd4, 32'd5: begin
                st_vld[p]    = (vec[n][0] == 32'd4);
                st_sq_idx[p] = lsq_pkg::sq_idx_t'(vec[n][4]);
                st_paddr[p]  = vec[n][5];
                st_mask[p]   = lsq_pkg::byte_mask_t'(vec[n][6]);
                chk_pend[p]  = 1'b1;
                exp_vio[p]   = vec[n][9][0];
                exp_rob[p]   = lsq_pkg::rob_idx_t'(vec[n][7]);
                exp_pc[p]    = vec[n][8];
            end
            default: stop_run("unknown operation code in the vector file");
        endcase
    endtask

    task automatic check_reports();
        for (int s = 0; s < lsq_pkg::STU_NUM; s++) begin
            if (chk_pend[s]) begin
                assert (vio[s] === exp_vio[s])
                    else report_mismatch(s, "o_vio", 32'(vio[s]), 32'(exp_vio[s]));
                if (exp_vio[s]) begin
                    assert (vio_rob_idx[s] === exp_rob[s])
                        else report_mismatch(s, "o_vio_rob_idx", 32'(vio_rob_idx[s]),
                                             32'(exp_rob[s]));
                    assert (vio_pc[s] === exp_pc[s])
                        else report_mismatch(s, "o_vio_pc", vio_pc[s], exp_pc[s]);
                end
            end
        end
        chk_pend = '0;
    endtask

    initial begin
        int          i;
        logic [31:0] grp;
        clk      = 1'b0;
        rst_n    = 1'b0;
        cycles   = 0;
        limit    = 0;
        chk_pend = '0;
        exp_vio  = '0;
        clear_inputs();
        load_vectors();
        limit = n_lines + 20;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;
        i = 0;
        while (i < n_lines) begin
            @(posedge clk);
            #1;
            // reports from the previous cycle's stores are settled here
            check_reports();
            clear_inputs();
            do begin
                apply_line(i);
                grp = vec[i][1];
                i++;
            end while (grp != 0 && i < n_lines);
        end
        @(posedge clk);
        #1;
        check_reports();
        $display("TEST OK");
        $finish;
    end

endmodule
